// ==== src/icache_pkg.sv ====
/*
  Shared geometry, address layout and controller states of the two-way
  instruction cache. Every other file refers to these by scoped names.
*/
package icache_pkg;

  // Word and address widths
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;

  // Line geometry, four words per line
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * WORD_W;

  // Set geometry
  localparam int SETS       = 16;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 2;

  // Instructions are word aligned, so two byte bits are always dropped
  localparam int BYTE_OFF_W = 2;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

  // Accepted fetch address, seen either raw or split into lookup fields
  // Raw view goes to memory, field view drives tag compare and word select
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    index;
      logic [OFFSET_W-1:0]   offset;
      logic [BYTE_OFF_W-1:0] byte_off;
    } fields;
  } icache_addr_u;

  // Miss sequencing states
  // IDLE covers both waiting for a request and the lookup cycle
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    MEM_REQ  = 2'd1,
    MEM_WAIT = 2'd2,
    DRAIN    = 2'd3
  } icache_state_e;

endpackage

// ==== src/icache_way.sv ====
/*
  One way of the instruction cache. Holds valid bits, tags and line data
  for every set, compares the indexed tag and returns the addressed word.
  A fill writes a whole line and marks the set valid.
*/
module icache_way (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Lookup port, driven from the accepted address register
  input  logic [icache_pkg::INDEX_W-1:0]      index_i,
  input  logic [icache_pkg::TAG_W-1:0]        tag_i,
  input  logic [icache_pkg::OFFSET_W-1:0]     offset_i,

  // Fill port, shares the lookup index and tag
  input  logic                                fill_i,
  input  logic [icache_pkg::LINE_W-1:0]       fill_line_i,

  output logic                                hit_o,
  output logic [icache_pkg::WORD_W-1:0]       word_o
);

  // Valid bit per set
  logic [icache_pkg::SETS-1:0] valid_q;

  // Tag store
  logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::SETS];

  // Line store, each entry split into words for the offset select
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_W-1:0] line_mem [icache_pkg::SETS];

  // Stored line of the indexed set
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_W-1:0] line_sel;

  assign line_sel = line_mem[index_i];

  // Tag compare, qualified by the valid bit
  assign hit_o  = valid_q[index_i] && (tag_mem[index_i] == tag_i);

  // Word picked from the line regardless of hit
  // Way select only forwards it when this way hits
  assign word_o = line_sel[offset_i];

  // Valid bits start cleared, set by a fill
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // Tag and data written together on a fill
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_mem[index_i]  <= tag_i;
      line_mem[index_i] <= fill_line_i;
    end
  end

endmodule

// ==== src/icache_way_select.sv ====
/*
  Merges the hit results of the two ways and keeps one LRU bit per set.
  The LRU bit names the victim way for the next miss in that set.
*/
module icache_way_select (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic [icache_pkg::INDEX_W-1:0]      index_i,

  // Per-way lookup results
  input  logic                                hit0_i,
  input  logic                                hit1_i,
  input  logic [icache_pkg::WORD_W-1:0]       word0_i,
  input  logic [icache_pkg::WORD_W-1:0]       word1_i,

  // Replacement update from the controller
  input  logic                                lru_update_i,
  input  logic [1:0]                          fill_way_i,

  output logic                                hit_o,
  output logic [icache_pkg::WORD_W-1:0]       hit_word_o,
  output logic                                victim_o
);

  // One bit per set, holds the index of the victim way
  logic [icache_pkg::SETS-1:0] lru_q;

  assign hit_o      = hit0_i || hit1_i;
  assign hit_word_o = hit1_i ? word1_i : word0_i;
  assign victim_o   = lru_q[index_i];

  // A hit makes the other way the victim
  // A fill never coincides with a hit on the same set, so the way that
  // was not filled becomes the victim
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lru_q <= '0;
    end else if (lru_update_i) begin
      if (hit_o) begin
        lru_q[index_i] <= hit0_i;
      end else begin
        lru_q[index_i] <= fill_way_i[0];
      end
    end
  end

  // A line may live in only one way of a set
  // Holds as long as fills only go to a set after a miss in both ways
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(hit0_i && hit1_i))
    else $error("icache: both ways hit in set %0d", index_i);

endmodule

// ==== src/icache_controller.sv ====
/*
  Miss sequencer of the instruction cache. Accepts fetch requests, answers
  hits from the lookup, runs the memory handshake on a miss and fills the
  victim way. A kill from fetch drops the pending miss and any late line.
*/
module icache_controller (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Fetch request side
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic                                kill_i,

  // Lookup interface
  output logic                                lookup_o,
  input  logic                                hit_i,
  input  logic [icache_pkg::WORD_W-1:0]       hit_word_i,
  input  logic                                victim_i,

  // Memory side
  output logic                                mem_req_valid_o,
  input  logic                                mem_req_ready_i,
  input  logic                                mem_rsp_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]       mem_rsp_data_i,
  input  logic [icache_pkg::OFFSET_W-1:0]     offset_i,

  // Fill and replacement control
  output logic                                fill_o,
  output logic [1:0]                          fill_way_o,
  output logic                                lru_update_o,

  // Fetch response, one cycle pulse
  output logic                                rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0]       rsp_data_o
);

  icache_pkg::icache_state_e state_q, state_d;

  // High in the cycle after a request was accepted
  logic lookup_q;
  logic accept;
  logic hit_rsp;
  logic miss_start;
  logic fill;

  // Returned line viewed as words
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_W-1:0] rsp_line;

  assign rsp_line = mem_rsp_data_i;

  // No new request while a lookup or a miss is in flight
  assign req_ready_o = (state_q == icache_pkg::IDLE) && !lookup_q;
  assign accept      = req_valid_i && req_ready_o;

  // Accept strobe, loads the address register and raises the lookup flag
  assign lookup_o    = accept;

  // Lookup outcome, a kill in this cycle cancels both paths
  assign hit_rsp     = lookup_q && hit_i && !kill_i;
  assign miss_start  = lookup_q && !hit_i && !kill_i;

  // Line arrives and nobody killed the miss meanwhile
  assign fill        = (state_q == icache_pkg::MEM_WAIT) && mem_rsp_valid_i && !kill_i;

  assign fill_o          = fill;
  assign fill_way_o      = victim_i ? 2'b10 : 2'b01;
  assign lru_update_o    = hit_rsp || fill;
  assign mem_req_valid_o = (state_q == icache_pkg::MEM_REQ);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::IDLE: begin
        if (miss_start) begin
          state_d = icache_pkg::MEM_REQ;
        end
      end
      icache_pkg::MEM_REQ: begin
        // Once memory took the request its line has to be drained
        if (mem_req_ready_i) begin
          state_d = kill_i ? icache_pkg::DRAIN : icache_pkg::MEM_WAIT;
        end else if (kill_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      icache_pkg::MEM_WAIT: begin
        if (mem_rsp_valid_i) begin
          state_d = icache_pkg::IDLE;
        end else if (kill_i) begin
          state_d = icache_pkg::DRAIN;
        end
      end
      icache_pkg::DRAIN: begin
        // Swallow the stale line
        if (mem_rsp_valid_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::IDLE;
      lookup_q    <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      lookup_q    <= accept;
      rsp_valid_o <= hit_rsp || fill;
    end
  end

  // Response word from the cache on a hit, from the new line on a fill
  always_ff @(posedge clk_i) begin
    if (fill) begin
      rsp_data_o <= rsp_line[offset_i];
    end else if (hit_rsp) begin
      rsp_data_o <= hit_word_i;
    end
  end

  // Memory request is only withdrawn by a kill
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_valid_o && !mem_req_ready_i && !kill_i) |=> mem_req_valid_o)
    else $error("icache: memory request dropped before ready");

  // A line swallowed in DRAIN is neither filled nor returned to fetch
  // Covers both ways in, kill in MEM_REQ and kill in MEM_WAIT
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == icache_pkg::DRAIN) |=> !rsp_valid_o)
    else $error("icache: fill or response from a drained line");

endmodule

// ==== src/icache_top.sv ====
/*
  Top level of the two-way instruction cache between fetch and a line-wide
  instruction memory. Registers the accepted address and wires the ways,
  the way-select block and the miss controller together.
*/
module icache_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Fetch side
  input  logic                                req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0]       req_addr_i,
  output logic                                req_ready_o,
  input  logic                                kill_i,
  output logic                                rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0]       rsp_data_o,

  // Memory side
  output logic                                mem_req_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]       mem_req_addr_o,
  input  logic                                mem_req_ready_i,
  input  logic                                mem_rsp_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]       mem_rsp_data_i
);

  // Accepted address, held for the lookup and the whole miss
  icache_pkg::icache_addr_u addr_q;

  logic                          lookup;
  logic                          hit0, hit1, hit, victim;
  logic [icache_pkg::WORD_W-1:0] word0, word1, hit_word;
  logic                          fill, lru_update;
  logic [1:0]                    fill_way;

  always_ff @(posedge clk_i) begin
    if (lookup) begin
      addr_q.raw <= req_addr_i;
    end
  end

  // Line aligned request address
  assign mem_req_addr_o = {addr_q.fields.tag, addr_q.fields.index,
                           {(icache_pkg::OFFSET_W + icache_pkg::BYTE_OFF_W){1'b0}}};

  icache_way way0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .index_i     (addr_q.fields.index),
    .tag_i       (addr_q.fields.tag),
    .offset_i    (addr_q.fields.offset),
    .fill_i      (fill && fill_way[0]),
    .fill_line_i (mem_rsp_data_i),
    .hit_o       (hit0),
    .word_o      (word0)
  );

  icache_way way1 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .index_i     (addr_q.fields.index),
    .tag_i       (addr_q.fields.tag),
    .offset_i    (addr_q.fields.offset),
    .fill_i      (fill && fill_way[1]),
    .fill_line_i (mem_rsp_data_i),
    .hit_o       (hit1),
    .word_o      (word1)
  );

  icache_way_select u_way_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .index_i      (addr_q.fields.index),
    .hit0_i       (hit0),
    .hit1_i       (hit1),
    .word0_i      (word0),
    .word1_i      (word1),
    .lru_update_i (lru_update),
    .fill_way_i   (fill_way),
    .hit_o        (hit),
    .hit_word_o   (hit_word),
    .victim_o     (victim)
  );

  icache_controller u_controller (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .kill_i          (kill_i),
    .lookup_o        (lookup),
    .hit_i           (hit),
    .hit_word_i      (hit_word),
    .victim_i        (victim),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .offset_i        (addr_q.fields.offset),
    .fill_o          (fill),
    .fill_way_o      (fill_way),
    .lru_update_o    (lru_update),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_data_o      (rsp_data_o)
  );

  // Address must not move while memory stalls the request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_valid_o && !mem_req_ready_i) |=> $stable(mem_req_addr_o))
    else $error("icache: memory request address changed under back-pressure");

endmodule

// ==== sim/icache_checker.sv ====
/*
  Watches the cache ports and compares them every cycle with a reference
  two-way LRU cache. Prints a line per finished request and counts errors.
*/
module icache_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  logic [31:0] req_addr_i,
  input  logic        req_ready_i,
  input  logic        kill_i,
  input  logic        rsp_valid_i,
  input  logic [31:0] rsp_data_i,
  input  logic        mem_req_valid_i,
  input  logic [31:0] mem_req_addr_i,
  input  logic        mem_req_ready_i,
  input  logic        mem_rsp_valid_i,
  output int          accepted_o,
  output int          responded_o,
  output int          killed_o,
  output int          errors_o,
  output logic        busy_o
);

  // Phases of one request as seen from the ports
  typedef enum int {S_IDLE, S_LOOKUP, S_MREQ, S_MWAIT, S_DRAIN} phase_e;

  // Reference cache, tags and valid bits only
  logic        valid_m [2][icache_pkg::SETS];
  logic [23:0] tag_m   [2][icache_pkg::SETS];
  logic        lru_m   [icache_pkg::SETS];

  phase_e      phase;
  logic [31:0] addr;
  logic        rsp_due;
  logic        was_hit;
  int          req_id;

  // Same memory rule as the memory model
  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL @%0t %s got %h expected %h", $time, name, got, exp);
      errors_o++;
    end
  endtask

  task automatic report_kill(input string where);
    killed_o++;
    $display("request %0d addr %h killed %s", req_id, addr, where);
  endtask

  always @(negedge clk_i) begin
    logic [3:0]  idx;
    logic [23:0] tag;
    logic        hit;
    logic        way;
    if (!rst_ni) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        valid_m[0][s] = 1'b0;
        valid_m[1][s] = 1'b0;
        lru_m[s]      = 1'b0;
      end
      phase       = S_IDLE;
      rsp_due     = 1'b0;
      was_hit     = 1'b0;
      req_id      = 0;
      accepted_o  = 0;
      responded_o = 0;
      killed_o    = 0;
      errors_o    = 0;
      busy_o      = 1'b0;
    end else begin
      idx = addr[7:4];
      tag = addr[31:8];

      // Outputs of this cycle against the model
      check_value("req_ready_o", req_ready_i, phase == S_IDLE);
      check_value("mem_req_valid_o", mem_req_valid_i, phase == S_MREQ);
      if (mem_req_valid_i && phase == S_MREQ) begin
        check_value("mem_req_addr_o", mem_req_addr_i, {addr[31:4], 4'h0});
      end
      check_value("rsp_valid_o", rsp_valid_i, rsp_due);
      if (rsp_valid_i) begin
        responded_o++;
      end
      if (rsp_valid_i && rsp_due) begin
        check_value("rsp_data_o", rsp_data_i, expected_word({addr[31:2], 2'b00}));
        $display("request %0d addr %h answered %s", req_id, addr,
                 was_hit ? "on a hit" : "after a refill");
      end
      rsp_due = 1'b0;

      case (phase)
        S_IDLE: begin
          if (req_valid_i && req_ready_i) begin
            addr = req_addr_i;
            req_id++;
            accepted_o++;
            phase = S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          hit = 1'b0;
          way = 1'b0;
          for (int w = 0; w < 2; w++) begin
            if (valid_m[w][idx] && tag_m[w][idx] == tag) begin
              hit = 1'b1;
              way = w[0];
            end
          end
          if (kill_i) begin
            report_kill("in the lookup");
            phase = S_IDLE;
          end else if (hit) begin
            // Other way becomes the victim
            lru_m[idx] = !way;
            rsp_due    = 1'b1;
            was_hit    = 1'b1;
            phase      = S_IDLE;
          end else begin
            phase = S_MREQ;
          end
        end
        S_MREQ: begin
          if (kill_i) begin
            report_kill(mem_req_ready_i ? "as memory took the request"
                                        : "before the memory request");
          end
          if (mem_req_ready_i) begin
            phase = kill_i ? S_DRAIN : S_MWAIT;
          end else if (kill_i) begin
            phase = S_IDLE;
          end
        end
        S_MWAIT: begin
          if (mem_rsp_valid_i && !kill_i) begin
            // Fill the LRU victim, the filled way is now most recent
            way              = lru_m[idx];
            valid_m[way][idx] = 1'b1;
            tag_m[way][idx]   = tag;
            lru_m[idx]        = !way;
            rsp_due           = 1'b1;
            was_hit           = 1'b0;
            phase             = S_IDLE;
          end else if (kill_i) begin
            report_kill("while waiting for memory");
            phase = mem_rsp_valid_i ? S_IDLE : S_DRAIN;
          end
        end
        S_DRAIN: begin
          // Stale line is dropped without a fill
          if (mem_rsp_valid_i) begin
            phase = S_IDLE;
          end
        end
        default: phase = S_IDLE;
      endcase
      busy_o = (phase != S_IDLE) || rsp_due;
    end
  end

endmodule

// ==== sim/tb_icache.sv ====
/*
  Testbench top of the two-way instruction cache. Drives random fetch
  requests and kills, models a line-wide memory with random ready and
  latency, and leaves the per-cycle comparison to icache_checker.
*/
module tb_icache;

  localparam int N_REQS     = 300;
  // Generous cycle bound per request, memory stalls included
  localparam int WORST_CYC  = 64;
  localparam int CLK_PERIOD = 100;
  localparam int LIMIT_CYC  = N_REQS * WORST_CYC + 8;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            req_valid, req_ready, kill, rsp_valid;
  logic [icache_pkg::ADDR_W-1:0]   req_addr, mem_req_addr;
  logic [icache_pkg::WORD_W-1:0]   rsp_data;
  logic                            mem_req_valid, mem_req_ready, mem_rsp_valid;
  logic [icache_pkg::LINE_W-1:0]   mem_rsp_data;

  // Counters and state reported by the checker
  int   accepted, responded, killed, errors;
  logic busy;

  logic [31:0] rnd;
  int          sent;
  logic        acc_seen, mem_acc_seen;
  logic [31:0] mem_addr_seen;

  // Memory model, one outstanding line at most
  logic        mem_pending;
  int          mem_delay;
  logic [31:0] mem_line_addr;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory content rule, word address mixed into the data
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [127:0] line_data(input logic [31:0] line_addr);
    logic [127:0] data;
    for (int w = 0; w < 4; w++) begin
      data[w*32 +: 32] = mem_word(line_addr + 32'(w * 4));
    end
    return data;
  endfunction

  // Three tags over four sets, so sets often see more tags than ways
  function automatic logic [31:0] pick_addr(input logic [31:0] r);
    logic [23:0] tag;
    tag = 24'h000100 + 24'(r[1:0] % 3);
    return {tag, 2'b00, r[5:4], r[9:8], 2'b00};
  endfunction

  icache_top dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_addr_i      (req_addr),
    .req_ready_o     (req_ready),
    .kill_i          (kill),
    .rsp_valid_o     (rsp_valid),
    .rsp_data_o      (rsp_data),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_data_i  (mem_rsp_data)
  );

  icache_checker u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_addr_i      (req_addr),
    .req_ready_i     (req_ready),
    .kill_i          (kill),
    .rsp_valid_i     (rsp_valid),
    .rsp_data_i      (rsp_data),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_addr_i  (mem_req_addr),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .accepted_o      (accepted),
    .responded_o     (responded),
    .killed_o        (killed),
    .errors_o        (errors),
    .busy_o          (busy)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    rnd           = 32'd17137;
    rst_ni        = 1'b0;
    rnd           = xorshift32(rnd);
    // First request already valid in reset, so the address register starts known
    req_valid     = 1'b1;
    req_addr      = pick_addr(rnd);
    kill          = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    mem_pending   = 1'b0;
    mem_delay     = 0;
    mem_line_addr = '0;
    sent          = 0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    while (sent < N_REQS || busy || mem_pending || mem_rsp_valid) begin
      // Handshakes of the coming edge, sampled mid cycle
      @(negedge clk_i);
      acc_seen      = req_valid && req_ready;
      mem_acc_seen  = mem_req_valid && mem_req_ready;
      mem_addr_seen = mem_req_addr;
      @(posedge clk_i);
      #10;
      if (acc_seen) begin
        sent++;
      end
      // Fetch side, a pending request holds until taken
      if (acc_seen || !req_valid) begin
        rnd       = xorshift32(rnd);
        req_valid = (sent < N_REQS) && (rnd[3:0] != 4'd0);
        req_addr  = pick_addr(rnd >> 8);
      end
      rnd           = xorshift32(rnd);
      kill          = (rnd[7:4] == 4'd0);
      mem_req_ready = rnd[8];
      mem_rsp_valid = 1'b0;
      if (mem_acc_seen) begin
        mem_pending   = 1'b1;
        mem_delay     = int'(rnd[14:12]) % 6;
        mem_line_addr = mem_addr_seen;
      end else if (mem_pending) begin
        if (mem_delay == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp_data  = line_data(mem_line_addr);
          mem_pending   = 1'b0;
        end else begin
          mem_delay--;
        end
      end
    end

    // A few idle cycles to catch stray responses
    repeat (4) @(posedge clk_i);
    #10;
    $display("requests %0d responses %0d kills %0d errors %0d",
             accepted, responded, killed, errors);
    if (responded + killed != accepted || accepted != N_REQS) begin
      $display("Responses plus kills do not add up to the %0d accepted requests", accepted);
    end
    if (errors == 0 && accepted == N_REQS && responded + killed == accepted) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(LIMIT_CYC * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d cycles", LIMIT_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
src/icache_pkg.sv
src/icache_way.sv
src/icache_way_select.sv
src/icache_controller.sv
src/icache_top.sv
sim/icache_checker.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_way.sv
  - src/icache_way_select.sv
  - src/icache_controller.sv
  - src/icache_top.sv
  - target: test
    files:
      - sim/icache_checker.sv
      - sim/tb_icache.sv
